// ==== rtl/decPkg.sv ====
// WEX decoder package
// field widths, decode types and encoded constants shared by the decode pipeline
package decPkg;

	localparam int laneWordW = 32;
	localparam int laneCount = 3;
	localparam int gprIdxW   = 6;
	localparam int immW      = 33;
	localparam int uOpW      = 9;

	// decoded register index, 0..31 in use
	typedef logic [gprIdxW-1:0] gprIdxT;

	// sign-extended immediate
	typedef logic [immW-1:0] immT;

	// condition code in 8:6, opcode in 5:0
	typedef logic [uOpW-1:0] uCmdT;

	// width class in 8:6, low bits zero
	typedef logic [uOpW-1:0] uIxtT;

	typedef enum logic [1:0]
	{
		modeScalar,
		modeWex2,
		modeWex3
	} bundleModeT;

	// null register
	localparam gprIdxT zzrReg = 6'd63;

	// condition codes
	localparam logic [2:0] condAlways = 3'd0;
	localparam logic [2:0] condTrue   = 3'd2;
	localparam logic [2:0] condFalse  = 3'd3;

	// width class of a 128-bit op
	localparam logic [2:0] ixtWide = 3'd5;

	// opcode group 5:1 that treats Rm as a base register
	localparam logic [4:0] baseOpHi = 5'd2;

endpackage

// ==== rtl/laneDecoder.sv ====
// lane decoder
// splits one 32-bit word into registers, immediate, command and the WEX flag
`timescale 1ns/10ps

module laneDecoder
(
	input  logic [decPkg::laneWordW-1:0] instrWord,
	input  logic                         wexEnable,
	output decPkg::gprIdxT               regN,
	output decPkg::gprIdxT               regM,
	output decPkg::gprIdxT               regO,
	output decPkg::immT                  imm,
	output decPkg::uCmdT                 uCmd,
	output decPkg::uIxtT                 uIxt,
	output logic                         wexFlag
);

	// prefix nibbles of the two 32-bit forms
	localparam logic [3:0] prefixF = 4'hF;
	localparam logic [3:0] prefixE = 4'hE;

	logic [3:0] prefix;
	logic [5:0] opcode;
	logic       isFop;
	logic       isEop;
	logic       hasImm;
	logic [2:0] cond;

	assign prefix = instrWord[15:12];
	assign opcode = instrWord[31:26];
	assign isFop  = (prefix == prefixF);
	assign isEop  = (prefix == prefixE);

	// opcode bit 5 trades Ro for an immediate
	assign hasImm = opcode[5];

	// bit 10 of a predicated op means execute if false
	always_comb
	begin
		if (!isEop)
			cond = decPkg::condAlways;
		else if (instrWord[10])
			cond = decPkg::condFalse;
		else
			cond = decPkg::condTrue;
	end

	always_comb
	begin
		regN = decPkg::zzrReg;
		regM = decPkg::zzrReg;
		regO = decPkg::zzrReg;
		imm  = '0;
		uCmd = '0;
		uIxt = '0;
		if (isFop || isEop)
		begin
			regN = {1'b0, instrWord[8:4]};
			regM = {1'b0, instrWord[25:21]};
			regO = hasImm ? decPkg::zzrReg : {1'b0, instrWord[20:16]};
			if (hasImm)
				imm = {{(decPkg::immW-10){instrWord[25]}}, instrWord[25:16]};
			uCmd = {cond, opcode};
			uIxt = {instrWord[3:1], 6'b0};
		end
	end

	// plain ops flag WEX with bit 10, pred-WEX uses bits 11 and 9
	assign wexFlag = wexEnable &&
		((isFop && instrWord[10]) || (isEop && instrWord[11] && instrWord[9]));

endmodule

// ==== rtl/bundleRouter.sv ====
// bundle router
// picks scalar, two-wide or three-wide issue and steers lane decodes into A/B/C
`timescale 1ns/10ps

module bundleRouter
(
	input  decPkg::gprIdxT     regN0, regN1, regN2,
	input  decPkg::gprIdxT     regM0, regM1, regM2,
	input  decPkg::gprIdxT     regO0, regO1, regO2,
	input  decPkg::immT        imm0, imm1, imm2,
	input  decPkg::uCmdT       uCmd0, uCmd1, uCmd2,
	input  decPkg::uIxtT       uIxt0, uIxt1, uIxt2,
	input  logic               wexFlag0,
	input  logic               wexFlag1,
	output decPkg::gprIdxT     regAN, regAM, regAO,
	output decPkg::immT        immA,
	output decPkg::uCmdT       uCmdA,
	output decPkg::uIxtT       uIxtA,
	output decPkg::gprIdxT     regBN, regBM, regBO,
	output decPkg::immT        immB,
	output decPkg::uCmdT       uCmdB,
	output decPkg::uIxtT       uIxtB,
	output decPkg::gprIdxT     regCN, regCM, regCO,
	output decPkg::immT        immC,
	output decPkg::uCmdT       uCmdC,
	output decPkg::uIxtT       uIxtC,
	output decPkg::bundleModeT mode
);

	// lane 2 never carries the WEX chain further
	always_comb
	begin
		if (wexFlag0 && wexFlag1)
			mode = decPkg::modeWex3;
		else if (wexFlag0)
			mode = decPkg::modeWex2;
		else
			mode = decPkg::modeScalar;
	end

	always_comb
	begin
		// lane A defaults to the first word, B and C idle
		regAN = regN0;
		regAM = regM0;
		regAO = regO0;
		immA  = imm0;
		uCmdA = uCmd0;
		uIxtA = uIxt0;
		regBN = decPkg::zzrReg;
		regBM = decPkg::zzrReg;
		regBO = decPkg::zzrReg;
		immB  = '0;
		uCmdB = '0;
		uIxtB = '0;
		regCN = decPkg::zzrReg;
		regCM = decPkg::zzrReg;
		regCO = decPkg::zzrReg;
		immC  = '0;
		uCmdC = '0;
		uIxtC = '0;

		case (mode)
			decPkg::modeWex3:
			begin
				// bundle is issued back to front
				regAN = regN2;
				regAM = regM2;
				regAO = regO2;
				immA  = imm2;
				uCmdA = uCmd2;
				uIxtA = uIxt2;
				regBN = regN1;
				regBM = regM1;
				regBO = regO1;
				immB  = imm1;
				uCmdB = uCmd1;
				uIxtB = uIxt1;
				regCN = regN0;
				regCM = regM0;
				regCO = regO0;
				immC  = imm0;
				uCmdC = uCmd0;
				uIxtC = uIxt0;
			end
			decPkg::modeWex2:
			begin
				regAN = regN1;
				regAM = regM1;
				regAO = regO1;
				immA  = imm1;
				uCmdA = uCmd1;
				uIxtA = uIxt1;
				regBN = regN0;
				regBM = regM0;
				regBO = regO0;
				immB  = imm0;
				uCmdB = uCmd0;
				uIxtB = uIxt0;
			end
			default:
			begin
				// idle lanes still read A's Rn through O
				regBO = regN0;
				regCO = regN0;
			end
		endcase
	end

endmodule

// ==== rtl/laneIssueStage.sv ====
// lane issue stage
// expands 128-bit ops over lanes A/B with even/odd pairs, then registers the bundle
`timescale 1ns/10ps

module laneIssueStage
(
	input  logic               clock,
	input  logic               arstN,
	input  decPkg::bundleModeT mode,
	input  decPkg::gprIdxT     regAN, regAM, regAO,
	input  decPkg::immT        immA,
	input  decPkg::uCmdT       uCmdA,
	input  decPkg::uIxtT       uIxtA,
	input  decPkg::gprIdxT     regBN, regBM, regBO,
	input  decPkg::immT        immB,
	input  decPkg::uCmdT       uCmdB,
	input  decPkg::uIxtT       uIxtB,
	input  decPkg::gprIdxT     regCN, regCM, regCO,
	input  decPkg::immT        immC,
	input  decPkg::uCmdT       uCmdC,
	input  decPkg::uIxtT       uIxtC,
	output decPkg::gprIdxT     idRegS, idRegT, idRegM,
	output decPkg::immT        idImmA,
	output decPkg::uCmdT       idUCmdA,
	output decPkg::uIxtT       idUIxtA,
	output decPkg::gprIdxT     idRegU, idRegV, idRegN,
	output decPkg::immT        idImmB,
	output decPkg::uCmdT       idUCmdB,
	output decPkg::uIxtT       idUIxtB,
	output decPkg::gprIdxT     idRegX, idRegY, idRegO,
	output decPkg::immT        idImmC,
	output decPkg::uCmdT       idUCmdC,
	output decPkg::uIxtT       idUIxtC
);

	logic           isDual;
	logic           pairMO;
	decPkg::gprIdxT nxtAN, nxtAM, nxtAO;
	decPkg::gprIdxT nxtBN, nxtBM, nxtBO;
	decPkg::gprIdxT nxtCN, nxtCM, nxtCO;
	decPkg::immT    nxtImmB, nxtImmC;
	decPkg::uCmdT   nxtUCmdB, nxtUCmdC;
	decPkg::uIxtT   nxtUIxtB, nxtUIxtC;

	// low half on the even register, high half on the odd one
	function automatic decPkg::gprIdxT pairReg(input decPkg::gprIdxT r, input logic odd);
		if (r == decPkg::zzrReg)
			return r;
		return {r[5:1], odd};
	endfunction

	assign isDual = (uIxtA[8:6] == decPkg::ixtWide);

	// base-register ops keep Rm and Ro at 64 bits
	assign pairMO = (uCmdA[5:1] != decPkg::baseOpHi);

	always_comb
	begin
		nxtAN    = regAN;
		nxtAM    = regAM;
		nxtAO    = regAO;
		nxtBN    = regBN;
		nxtBM    = regBM;
		nxtBO    = regBO;
		nxtImmB  = immB;
		nxtUCmdB = uCmdB;
		nxtUIxtB = uIxtB;
		nxtCN    = regCN;
		nxtCM    = regCM;
		nxtCO    = regCO;
		nxtImmC  = immC;
		nxtUCmdC = uCmdC;
		nxtUIxtC = uIxtC;
		if (isDual)
		begin
			// lane B is taken by the high half, so a WEX partner moves to C
			if (mode != decPkg::modeScalar)
			begin
				nxtCN    = regBN;
				nxtCM    = regBM;
				nxtCO    = regBO;
				nxtImmC  = immB;
				nxtUCmdC = uCmdB;
				nxtUIxtC = uIxtB;
			end
			nxtImmB  = immA;
			nxtUCmdB = uCmdA;
			nxtUIxtB = uIxtA;
			nxtAN    = pairReg(regAN, 1'b0);
			nxtBN    = pairReg(regAN, 1'b1);
			nxtAM    = pairMO ? pairReg(regAM, 1'b0) : regAM;
			nxtBM    = pairMO ? pairReg(regAM, 1'b1) : regAM;
			nxtAO    = pairMO ? pairReg(regAO, 1'b0) : regAO;
			nxtBO    = pairMO ? pairReg(regAO, 1'b1) : regAO;
		end
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			idRegS  <= decPkg::zzrReg;
			idRegT  <= decPkg::zzrReg;
			idRegM  <= decPkg::zzrReg;
			idImmA  <= '0;
			idUCmdA <= '0;
			idUIxtA <= '0;
			idRegU  <= decPkg::zzrReg;
			idRegV  <= decPkg::zzrReg;
			idRegN  <= decPkg::zzrReg;
			idImmB  <= '0;
			idUCmdB <= '0;
			idUIxtB <= '0;
			idRegX  <= decPkg::zzrReg;
			idRegY  <= decPkg::zzrReg;
			idRegO  <= decPkg::zzrReg;
			idImmC  <= '0;
			idUCmdC <= '0;
			idUIxtC <= '0;
		end
		else
		begin
			idRegS  <= nxtAM;
			idRegT  <= nxtAO;
			idRegM  <= nxtAN;
			idImmA  <= immA;
			idUCmdA <= uCmdA;
			idUIxtA <= uIxtA;
			idRegU  <= nxtBM;
			idRegV  <= nxtBO;
			idRegN  <= nxtBN;
			idImmB  <= nxtImmB;
			idUCmdB <= nxtUCmdB;
			idUIxtB <= nxtUIxtB;
			idRegX  <= nxtCM;
			idRegY  <= nxtCO;
			idRegO  <= nxtCN;
			idImmC  <= nxtImmC;
			idUCmdC <= nxtUCmdC;
			idUIxtC <= nxtUIxtC;
		end
	end

	// a wide op issues its two halves on an even/odd Rn pair
	aRnPairSplit: assert property (@(posedge clock) disable iff (!arstN)
		(isDual && regAN != decPkg::zzrReg) |=> (idRegN[0] != idRegM[0]));

	// scalar bundles never issue a command on lane C
	aScalarLaneCIdle: assert property (@(posedge clock) disable iff (!arstN)
		(mode == decPkg::modeScalar) |=> (idUCmdC == '0));

endmodule

// ==== rtl/wexDecoder.sv ====
// three-wide WEX decoder
// three lane decoders feed the bundle router and a single registered issue stage
`timescale 1ns/10ps

module wexDecoder
(
	input  logic                                           clock,
	input  logic                                           arstN,
	input  logic [decPkg::laneCount*decPkg::laneWordW-1:0] istrWord,
	input  logic                                           wexEnable,
	output decPkg::gprIdxT                                 idRegS, idRegT, idRegM,
	output decPkg::immT                                    idImmA,
	output decPkg::uCmdT                                   idUCmdA,
	output decPkg::uIxtT                                   idUIxtA,
	output decPkg::gprIdxT                                 idRegU, idRegV, idRegN,
	output decPkg::immT                                    idImmB,
	output decPkg::uCmdT                                   idUCmdB,
	output decPkg::uIxtT                                   idUIxtB,
	output decPkg::gprIdxT                                 idRegX, idRegY, idRegO,
	output decPkg::immT                                    idImmC,
	output decPkg::uCmdT                                   idUCmdC,
	output decPkg::uIxtT                                   idUIxtC
);

	// per-word decodes
	decPkg::gprIdxT     regN0, regN1, regN2;
	decPkg::gprIdxT     regM0, regM1, regM2;
	decPkg::gprIdxT     regO0, regO1, regO2;
	decPkg::immT        imm0, imm1, imm2;
	decPkg::uCmdT       uCmd0, uCmd1, uCmd2;
	decPkg::uIxtT       uIxt0, uIxt1, uIxt2;
	logic               wexFlag0;
	logic               wexFlag1;

	// routed issue lanes
	decPkg::gprIdxT     regAN, regAM, regAO;
	decPkg::gprIdxT     regBN, regBM, regBO;
	decPkg::gprIdxT     regCN, regCM, regCO;
	decPkg::immT        immA, immB, immC;
	decPkg::uCmdT       uCmdA, uCmdB, uCmdC;
	decPkg::uIxtT       uIxtA, uIxtB, uIxtC;
	decPkg::bundleModeT mode;

	laneDecoder laneDec0 (
		.instrWord (istrWord[0 +: decPkg::laneWordW]), .wexEnable (wexEnable),
		.regN (regN0), .regM (regM0), .regO (regO0),
		.imm (imm0), .uCmd (uCmd0), .uIxt (uIxt0), .wexFlag (wexFlag0)
	);

	laneDecoder laneDec1 (
		.instrWord (istrWord[decPkg::laneWordW +: decPkg::laneWordW]), .wexEnable (wexEnable),
		.regN (regN1), .regM (regM1), .regO (regO1),
		.imm (imm1), .uCmd (uCmd1), .uIxt (uIxt1), .wexFlag (wexFlag1)
	);

	// last word ends any bundle so its flag goes nowhere
	laneDecoder laneDec2 (
		.instrWord (istrWord[2*decPkg::laneWordW +: decPkg::laneWordW]), .wexEnable (wexEnable),
		.regN (regN2), .regM (regM2), .regO (regO2),
		.imm (imm2), .uCmd (uCmd2), .uIxt (uIxt2), .wexFlag ()
	);

	bundleRouter bundleRouter (.*);

	laneIssueStage laneIssueStage (.*);

endmodule

// ==== bench/wexDecoderTb.sv ====
// WEX decoder testbench
// plays the pattern vectors through the decoder and checks all three issue lanes
`timescale 1ns/10ps

module wexDecoderTb;

	localparam int resetCycles  = 5;
	localparam int fieldsPerVec = 20;
	localparam int maxVectors   = 64;

	logic                                           clock;
	logic                                           arstN;
	logic [decPkg::laneCount*decPkg::laneWordW-1:0] istrWord;
	logic                                           wexEnable;

	decPkg::gprIdxT idRegS, idRegT, idRegM;
	decPkg::immT    idImmA;
	decPkg::uCmdT   idUCmdA;
	decPkg::uIxtT   idUIxtA;
	decPkg::gprIdxT idRegU, idRegV, idRegN;
	decPkg::immT    idImmB;
	decPkg::uCmdT   idUCmdB;
	decPkg::uIxtT   idUIxtB;
	decPkg::gprIdxT idRegX, idRegY, idRegO;
	decPkg::immT    idImmC;
	decPkg::uCmdT   idUCmdC;
	decPkg::uIxtT   idUIxtC;

	// one word per field and twenty fields per vector
	logic [95:0] patMem [0:maxVectors*fieldsPerVec-1];
	int          vecCount;
	int          cycleCount = 0;
	int          cycleLimit = resetCycles + 20;

	wexDecoder i_wexDecoder (.*);

	initial
		clock = 1'b0;

	always
		#10 clock = ~clock;

	always @(posedge clock)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("TEST FAIL");
			$fatal(1, "timeout: vectors did not finish");
		end
	end

	task automatic checkReg(input string sigName, input decPkg::gprIdxT expVal,
		input decPkg::gprIdxT actVal);
		if (actVal !== expVal)
		begin
			$display("FAIL %s expected %h actual %h", sigName, expVal, actVal);
			$display("TEST FAIL");
			$fatal(1, "register output mismatch");
		end
	endtask

	task automatic checkImm(input string sigName, input decPkg::immT expVal,
		input decPkg::immT actVal);
		if (actVal !== expVal)
		begin
			$display("FAIL %s expected %h actual %h", sigName, expVal, actVal);
			$display("TEST FAIL");
			$fatal(1, "immediate output mismatch");
		end
	endtask

	task automatic checkCmd(input string sigName, input decPkg::uCmdT expVal,
		input decPkg::uCmdT actVal);
		if (actVal !== expVal)
		begin
			$display("FAIL %s expected %h actual %h", sigName, expVal, actVal);
			$display("TEST FAIL");
			$fatal(1, "command output mismatch");
		end
	endtask

	task automatic checkIxt(input string sigName, input decPkg::uIxtT expVal,
		input decPkg::uIxtT actVal);
		if (actVal !== expVal)
		begin
			$display("FAIL %s expected %h actual %h", sigName, expVal, actVal);
			$display("TEST FAIL");
			$fatal(1, "extension output mismatch");
		end
	endtask

	// every lane idle with null registers and zero fields
	task automatic checkResetState();
		checkReg("idRegS", decPkg::zzrReg, idRegS);
		checkReg("idRegT", decPkg::zzrReg, idRegT);
		checkReg("idRegM", decPkg::zzrReg, idRegM);
		checkImm("idImmA", '0, idImmA);
		checkCmd("idUCmdA", '0, idUCmdA);
		checkIxt("idUIxtA", '0, idUIxtA);
		checkReg("idRegU", decPkg::zzrReg, idRegU);
		checkReg("idRegV", decPkg::zzrReg, idRegV);
		checkReg("idRegN", decPkg::zzrReg, idRegN);
		checkImm("idImmB", '0, idImmB);
		checkCmd("idUCmdB", '0, idUCmdB);
		checkIxt("idUIxtB", '0, idUIxtB);
		checkReg("idRegX", decPkg::zzrReg, idRegX);
		checkReg("idRegY", decPkg::zzrReg, idRegY);
		checkReg("idRegO", decPkg::zzrReg, idRegO);
		checkImm("idImmC", '0, idImmC);
		checkCmd("idUCmdC", '0, idUCmdC);
		checkIxt("idUIxtC", '0, idUIxtC);
	endtask

	// expected outputs follow the two input fields in port order
	task automatic checkOutputs(input int vecIdx);
		int base;
		base = vecIdx * fieldsPerVec + 2;
		checkReg("idRegS", decPkg::gprIdxT'(patMem[base]), idRegS);
		checkReg("idRegT", decPkg::gprIdxT'(patMem[base + 1]), idRegT);
		checkReg("idRegM", decPkg::gprIdxT'(patMem[base + 2]), idRegM);
		checkImm("idImmA", decPkg::immT'(patMem[base + 3]), idImmA);
		checkCmd("idUCmdA", decPkg::uCmdT'(patMem[base + 4]), idUCmdA);
		checkIxt("idUIxtA", decPkg::uIxtT'(patMem[base + 5]), idUIxtA);
		checkReg("idRegU", decPkg::gprIdxT'(patMem[base + 6]), idRegU);
		checkReg("idRegV", decPkg::gprIdxT'(patMem[base + 7]), idRegV);
		checkReg("idRegN", decPkg::gprIdxT'(patMem[base + 8]), idRegN);
		checkImm("idImmB", decPkg::immT'(patMem[base + 9]), idImmB);
		checkCmd("idUCmdB", decPkg::uCmdT'(patMem[base + 10]), idUCmdB);
		checkIxt("idUIxtB", decPkg::uIxtT'(patMem[base + 11]), idUIxtB);
		checkReg("idRegX", decPkg::gprIdxT'(patMem[base + 12]), idRegX);
		checkReg("idRegY", decPkg::gprIdxT'(patMem[base + 13]), idRegY);
		checkReg("idRegO", decPkg::gprIdxT'(patMem[base + 14]), idRegO);
		checkImm("idImmC", decPkg::immT'(patMem[base + 15]), idImmC);
		checkCmd("idUCmdC", decPkg::uCmdT'(patMem[base + 16]), idUCmdC);
		checkIxt("idUIxtC", decPkg::uIxtT'(patMem[base + 17]), idUIxtC);
	endtask

	task automatic applyVector(input int vecIdx);
		int base;
		base      = vecIdx * fieldsPerVec;
		wexEnable = patMem[base][0];
		istrWord  = patMem[base + 1][decPkg::laneCount*decPkg::laneWordW-1:0];
	endtask

	// unloaded entries keep their inverted address, which marks the end of the vectors
	task automatic loadPatterns();
		for (int i = 0; i < maxVectors * fieldsPerVec; i++)
			patMem[i] = ~96'(i);
		$readmemh("bench/wexPatterns.hex", patMem);
		vecCount = 0;
		while (vecCount < maxVectors &&
			patMem[vecCount * fieldsPerVec] != ~96'(vecCount * fieldsPerVec))
			vecCount++;
	endtask

	initial
	begin
		arstN     = 1'b0;
		istrWord  = '0;
		wexEnable = 1'b0;
		loadPatterns();
		cycleLimit = resetCycles + vecCount + 20;
		if (vecCount == 0)
		begin
			$display("TEST FAIL");
			$fatal(1, "no vectors were loaded from the pattern file");
		end
		repeat (resetCycles) @(negedge clock);
		checkResetState();
		arstN = 1'b1;

		// one vector per cycle and each checked one rising edge later
		for (int i = 0; i < vecCount; i++)
		begin
			applyVector(i);
			@(negedge clock);
			checkOutputs(i);
		end

		$display("TEST PASS");
		$finish;
	end

endmodule

// ==== bench/wexPatterns.hex ====
// columns: wexEnable, istrWord (lane2 lane1 lane0), then expected lane A S T M imm cmd ixt,
// lane B U V N imm cmd ixt, lane C X Y O imm cmd ixt
// scalar F ops, no immediate, positive and negative immediate
1 00000000000000001065f070 03 05 07 000000000 004 000 3f 07 3f 000000000 000 000 3f 07 3f 000000000 000 000
1 0000000000000000845af094 02 3f 09 00000005a 021 080 3f 09 3f 000000000 000 000 3f 09 3f 000000000 000 000
1 0000000000000000c3f0f1e2 1f 3f 1e 1fffffff0 030 040 3f 1e 3f 000000000 000 000 3f 1e 3f 000000000 000 000
// predicated true and false, then a non-32-bit prefix
1 00000000000000002822e046 01 02 04 000000000 08a 0c0 3f 04 3f 000000000 000 000 3f 04 3f 000000000 000 000
1 00000000000000002822e446 01 02 04 000000000 0ca 0c0 3f 04 3f 000000000 000 000 3f 04 3f 000000000 000 000
1 000000000000000028227046 3f 3f 3f 000000000 000 000 3f 3f 3f 000000000 000 000 3f 3f 3f 000000000 000 000
// unflagged lane 0 ignores lanes 1 and 2
1 2822e046845af0941065f070 03 05 07 000000000 004 000 3f 07 3f 000000000 000 000 3f 07 3f 000000000 000 000
// two-wide, three-wide, pred-WEX lane 0
1 000000002822e0461065f470 01 02 04 000000000 08a 0c0 03 05 07 000000000 004 000 3f 3f 3f 000000000 000 000
1 c3f0f1e2845af4941065f470 1f 3f 1e 1fffffff0 030 040 02 3f 09 00000005a 021 080 03 05 07 000000000 004 000
1 000000001065f0702822ea46 03 05 07 000000000 004 000 01 02 04 000000000 08a 0c0 3f 3f 3f 000000000 000 000
1 845af0941065f4702822ee46 02 3f 09 00000005a 021 080 03 05 07 000000000 004 000 01 02 04 000000000 0ca 0c0
// same bundles with WEX disabled fall back to scalar
0 000000002822e0461065f470 03 05 07 000000000 004 000 3f 07 3f 000000000 000 000 3f 07 3f 000000000 000 000
0 c3f0f1e2845af4941065f470 03 05 07 000000000 004 000 3f 07 3f 000000000 000 000 3f 07 3f 000000000 000 000
0 000000001065f0702822ea46 01 02 04 000000000 08a 0c0 3f 04 3f 000000000 000 000 3f 04 3f 000000000 000 000
// scalar dual-lane, base op, immediate form
1 000000000000000020c9f0ba 06 08 0a 000000000 008 140 07 09 0b 000000000 008 140 3f 0b 3f 000000000 000 000
1 000000000000000014c9f0ba 06 09 0a 000000000 005 140 06 09 0b 000000000 005 140 3f 0b 3f 000000000 000 000
1 0000000000000000a0c9f0da 06 3f 0c 0000000c9 028 140 07 3f 0d 0000000c9 028 140 3f 0d 3f 000000000 000 000
// WEX plus dual-lane moves lane B into lane C
1 0000000020c9f0ba1065f470 06 08 0a 000000000 008 140 07 09 0b 000000000 008 140 03 05 07 000000000 004 000
1 14c9f0ba845af4941065f470 06 09 0a 000000000 005 140 06 09 0b 000000000 005 140 02 3f 09 00000005a 021 080
// two-wide with an invalid lane 1, F with bits 11/9 and E with bit 10 only
1 00000000000000001065f470 3f 3f 3f 000000000 000 000 03 05 07 000000000 004 000 3f 3f 3f 000000000 000 000
1 000000002822e0461065fa70 03 05 07 000000000 004 000 3f 07 3f 000000000 000 000 3f 07 3f 000000000 000 000
1 000000001065f0702822e446 01 02 04 000000000 0ca 0c0 3f 04 3f 000000000 000 000 3f 04 3f 000000000 000 000
// back-to-back mix of modes
1 c3f0f1e2845af4941065f470 1f 3f 1e 1fffffff0 030 040 02 3f 09 00000005a 021 080 03 05 07 000000000 004 000
1 00000000000000001065f070 03 05 07 000000000 004 000 3f 07 3f 000000000 000 000 3f 07 3f 000000000 000 000
1 0000000020c9f0ba1065f470 06 08 0a 000000000 008 140 07 09 0b 000000000 008 140 03 05 07 000000000 004 000
1 000000000000000028227046 3f 3f 3f 000000000 000 000 3f 3f 3f 000000000 000 000 3f 3f 3f 000000000 000 000
1 000000000000000020c9f0ba 06 08 0a 000000000 008 140 07 09 0b 000000000 008 140 3f 0b 3f 000000000 000 000
1 000000002822e0461065f470 01 02 04 000000000 08a 0c0 03 05 07 000000000 004 000 3f 3f 3f 000000000 000 000

// ==== verilog.f ====
rtl/decPkg.sv
rtl/laneDecoder.sv
rtl/bundleRouter.sv
rtl/laneIssueStage.sv
rtl/wexDecoder.sv
bench/wexDecoderTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the WEX decoder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module wexDecoderTb

simOut=$(./obj_dir/VwexDecoderTb) || true
echo "$simOut"

if echo "$simOut" | grep -qx "TEST PASS"; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
